//--- sobel_edge.f
+incdir+verification
design/sobel_pkg.sv
design/line_buffer.sv
design/window_regs.sv
design/gradient_x.sv
design/gradient_y.sv
design/edge_combine.sv
design/stream_credit.sv
design/sobel_edge_top.sv
verification/sobel_edge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the Sobel edge testbench with Verilator, run it to sim.log and judge the log.

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module sobel_edge_tb \
    -f sobel_edge.f -o sobel_sim \
    && ./obj_dir/sobel_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
    && { echo "Result: failed"; exit 1; } \
    || { echo "Result: passed"; exit 0; }

//--- verification/sobel_model.svh
`ifndef SOBEL_MODEL_SVH
`define SOBEL_MODEL_SVH

// Every accepted pixel in stream order, and the results the DUT still owes.
int                   pixel_hist[$];
logic [MAG_WIDTH-1:0] exp_mag[$];
logic                 exp_edge[$];

// Positions before the start of the stream read as zero.
function automatic int history_pixel(input int index);
    if (index < 0)
        return 0;
    return pixel_hist[index];
endfunction

function automatic int abs_int(input int value);
    return (value < 0) ? -value : value;
endfunction

// The window of the newest pixel is taken purely by stream position.
task automatic record_pixel(input logic [PIXEL_WIDTH-1:0] pixel);
    int newest;
    int gx;
    int gy;
    int mag;
    int w [3][3];
    pixel_hist.push_back(int'(pixel));
    newest = pixel_hist.size() - 1;
    for (int r = 0; r < 3; r++)
    begin
        for (int c = 0; c < 3; c++)
        begin
            w[r][c] = history_pixel(newest - (2 - r) * LINE_WIDTH - (2 - c));
        end
    end
    gx = (w[0][2] + 2 * w[1][2] + w[2][2]) - (w[0][0] + 2 * w[1][0] + w[2][0]);
    gy = (w[2][0] + 2 * w[2][1] + w[2][2]) - (w[0][0] + 2 * w[0][1] + w[0][2]);
    mag = abs_int(gx) + abs_int(gy);
    if (mag > 255)
        mag = 255;
    exp_mag.push_back(MAG_WIDTH'(mag));
    exp_edge.push_back(mag > EDGE_THRESHOLD);
endtask

`endif

//--- verification/sobel_edge_tb.sv
module sobel_edge_tb
    import sobel_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FLAT_PIXELS   = 80;
    localparam int RANDOM_PIXELS = 200;
    localparam int GAP_PIXELS    = 200;
    localparam int COLUMN_PIXELS = 80;
    localparam int TOTAL_PIXELS  = FLAT_PIXELS + RANDOM_PIXELS + GAP_PIXELS + COLUMN_PIXELS;
    localparam int WATCHDOG_NS   = TOTAL_PIXELS * 40 * 4;

    localparam int IMAGE_RANDOM  = 0;
    localparam int IMAGE_FLAT    = 1;
    localparam int IMAGE_COLUMNS = 2;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   in_valid;
    logic [PIXEL_WIDTH-1:0] in_pixel;
    logic                   out_credit;
    logic                   in_credit;
    logic                   out_valid;
    logic [MAG_WIDTH-1:0]   out_magnitude;
    logic                   out_edge;

    // Written only by the stimulus process.
    logic [31:0] lfsr_state = 32'h4af2b538;
    int          cycle_num = 0;
    int          grants_used = 0;
    int          return_due[$];
    bit          prompt_credits = 1'b1;
    bit          steady_enable = 1'b0;
    int          steady_from = 0;
    int          steady_mag = 0;
    int          main_errors = 0;
    int          errors_base = 0;
    int          tests_failed = 0;

    // Written only by the monitor.
    int                   credit_pulses = 0;
    int                   credit_returns = 0;
    int                   out_count = 0;
    int                   accepted_count = 0;
    int                   monitor_errors = 0;
    logic [2:0]           valid_delay = 3'b000;
    logic [MAG_WIDTH-1:0] expect_mag;
    logic                 expect_edge;

    `include "sobel_model.svh"

    sobel_edge_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pixel      (in_pixel),
        .out_credit    (out_credit),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_magnitude (out_magnitude),
        .out_edge      (out_edge)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken.
    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // Column bands two pixels wide put opposite values under the outer kernel columns.
    function automatic logic [PIXEL_WIDTH-1:0] pixel_for(input int mode, input int index,
                                                         input logic [PIXEL_WIDTH-1:0] flat_value);
        if (mode == IMAGE_FLAT)
            return flat_value;
        if (mode == IMAGE_COLUMNS)
            return ((index / 2) % 2 == 0) ? '0 : '1;
        return PIXEL_WIDTH'(random_bits(PIXEL_WIDTH));
    endfunction

    task automatic report_mismatch(input string signal, input int expected, input int actual);
        $display("CHECK FAILED at %0d ns: %s expected %0d, actual %0d",
                 $time, signal, expected, actual);
        monitor_errors++;
    endtask

    task automatic note_protocol_error(input string message);
        $display("ERROR at %0d ns: %s", $time, message);
        monitor_errors++;
    endtask

    task automatic fail_test_step(input string message);
        $display("ERROR at %0d ns: %s", $time, message);
        main_errors++;
    endtask

    // One clock of consumer and source activity, driven just after the rising edge.
    task automatic run_cycle(input bit want_send, input logic [PIXEL_WIDTH-1:0] pixel,
                             output bit sent);
        int due;
        @(posedge clk);
        #1;
        cycle_num++;
        if (out_valid)
        begin
            due = cycle_num + 1 + (prompt_credits ? 0 : random_bits(4));
            if (return_due.size() != 0 && due <= return_due[$])
                due = return_due[$] + 1;
            return_due.push_back(due);
        end
        out_credit = 1'b0;
        if (return_due.size() != 0 && return_due[0] <= cycle_num)
        begin
            out_credit = 1'b1;
            void'(return_due.pop_front());
        end
        sent = want_send && (credit_pulses > grants_used);
        in_valid = sent;
        if (sent)
        begin
            in_pixel = pixel;
            grants_used++;
        end
    endtask

    task automatic idle_cycles(input int count);
        bit sent;
        repeat (count) run_cycle(1'b0, '0, sent);
    endtask

    task automatic send_image(input int mode, input int count, input bit gaps);
        int                     sent_count;
        bit                     want;
        bit                     sent;
        logic [PIXEL_WIDTH-1:0] flat_value;
        logic [PIXEL_WIDTH-1:0] pixel;
        flat_value = PIXEL_WIDTH'(random_bits(PIXEL_WIDTH));
        sent_count = 0;
        while (sent_count < count)
        begin
            pixel = pixel_for(mode, sent_count, flat_value);
            want = gaps ? (random_bits(2) != 0) : 1'b1;
            run_cycle(want, pixel, sent);
            if (sent)
                sent_count++;
        end
    endtask

    task automatic drain_pipeline();
        bit sent;
        while (out_count < grants_used || return_due.size() != 0 || out_credit || in_valid)
            run_cycle(1'b0, '0, sent);
        steady_enable = 1'b0;
    endtask

    // Outputs whose window lies wholly inside the new image must take a known value.
    task automatic arm_steady(input int mag);
        steady_from = accepted_count + 2 * LINE_WIDTH + 2;
        steady_mag = mag;
        steady_enable = 1'b1;
    endtask

    task automatic end_test(input int number, input string name);
        int errors;
        errors = main_errors + monitor_errors - errors_base;
        if (errors == 0)
            $display("test %0d %s: passed", number, name);
        else
        begin
            $display("test %0d %s: failed with %0d errors", number, name, errors);
            tests_failed++;
        end
        errors_base = main_errors + monitor_errors;
    endtask

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (in_credit)
                credit_pulses++;
            if (out_credit)
                credit_returns++;
            if (out_valid !== valid_delay[2])
                report_mismatch("out_valid", int'(valid_delay[2]), int'(out_valid));
            if (out_valid)
            begin
                if (exp_mag.size() == 0)
                    note_protocol_error("out_valid was raised with no pixel left to answer");
                else
                begin
                    expect_mag = exp_mag.pop_front();
                    expect_edge = exp_edge.pop_front();
                    if (out_magnitude !== expect_mag)
                        report_mismatch("out_magnitude", int'(expect_mag), int'(out_magnitude));
                    if (out_edge !== expect_edge)
                        report_mismatch("out_edge", int'(expect_edge), int'(out_edge));
                end
                if (steady_enable && out_count >= steady_from)
                begin
                    if (out_magnitude !== MAG_WIDTH'(steady_mag))
                        report_mismatch("out_magnitude", steady_mag, int'(out_magnitude));
                    if (out_edge !== (steady_mag > EDGE_THRESHOLD))
                        report_mismatch("out_edge", int'(steady_mag > EDGE_THRESHOLD),
                                        int'(out_edge));
                end
                out_count++;
            end
            if (out_count - credit_returns > OUT_CREDITS)
                note_protocol_error("more outputs wait for credit than the consumer owns");
            if (credit_pulses - credit_returns > OUT_CREDITS)
                note_protocol_error("more input grants are outstanding than output slots");
            if (in_valid)
            begin
                accepted_count++;
                record_pixel(in_pixel);
            end
            valid_delay = {valid_delay[1:0], in_valid};
        end
    end

    initial
    begin
        int pulses_before;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_pixel = '0;
        out_credit = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idle_cycles(OUT_CREDITS + 4);
        if (credit_pulses != OUT_CREDITS)
            fail_test_step($sformatf("%0d input credits came after reset instead of %0d",
                                     credit_pulses, OUT_CREDITS));
        pulses_before = credit_pulses;
        idle_cycles(50);
        if (credit_pulses != pulses_before)
            fail_test_step("input credits kept coming with no output credit returned");
        if (out_count != 0)
            fail_test_step("out_valid was raised before any pixel was sent");
        end_test(1, "reset and initial grants");

        arm_steady(0);
        send_image(IMAGE_FLAT, FLAT_PIXELS, 1'b0);
        drain_pipeline();
        end_test(2, "flat image");

        send_image(IMAGE_RANDOM, RANDOM_PIXELS, 1'b0);
        drain_pipeline();
        end_test(3, "random pixels at full rate");

        prompt_credits = 1'b0;
        send_image(IMAGE_RANDOM, GAP_PIXELS, 1'b1);
        drain_pipeline();
        prompt_credits = 1'b1;
        end_test(4, "random gaps and credit delays");

        arm_steady(255);
        send_image(IMAGE_COLUMNS, COLUMN_PIXELS, 1'b0);
        drain_pipeline();
        end_test(5, "column bands");

        if (out_count != accepted_count || accepted_count != TOTAL_PIXELS)
            fail_test_step($sformatf("%0d outputs for %0d accepted pixels, %0d sent",
                                     out_count, accepted_count, TOTAL_PIXELS));
        if (exp_mag.size() != 0)
            fail_test_step("expected results are left over at the end of the run");
        end_test(6, "final counts");

        $display("tests run: 6, tests failed: %0d, checks failed: %0d",
                 tests_failed, main_errors + monitor_errors);
        if (main_errors + monitor_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- design/sobel_edge_top.sv
module sobel_edge_top
    import sobel_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [PIXEL_WIDTH-1:0] in_pixel,
    input  logic                   out_credit,
    output logic                   in_credit,
    output logic                   out_valid,
    output logic [MAG_WIDTH-1:0]   out_magnitude,
    output logic                   out_edge
);

    logic                         advance;
    logic                         grad_valid;
    logic [PIXEL_WIDTH-1:0]       tap_row0;
    logic [PIXEL_WIDTH-1:0]       tap_row1;
    logic [PIXEL_WIDTH-1:0]       tap_row2;
    logic [PIXEL_WIDTH-1:0]       win_00;
    logic [PIXEL_WIDTH-1:0]       win_01;
    logic [PIXEL_WIDTH-1:0]       win_02;
    logic [PIXEL_WIDTH-1:0]       win_10;
    logic [PIXEL_WIDTH-1:0]       win_11;
    logic [PIXEL_WIDTH-1:0]       win_12;
    logic [PIXEL_WIDTH-1:0]       win_20;
    logic [PIXEL_WIDTH-1:0]       win_21;
    logic [PIXEL_WIDTH-1:0]       win_22;
    logic signed [GRAD_WIDTH-1:0] grad_x;
    logic signed [GRAD_WIDTH-1:0] grad_y;

    stream_credit u_stream_credit (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .advance    (advance),
        .grad_valid (grad_valid)
    );

    line_buffer u_line_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .pixel    (in_pixel),
        .tap_row0 (tap_row0),
        .tap_row1 (tap_row1),
        .tap_row2 (tap_row2)
    );

    window_regs u_window_regs (
        .clk      (clk), .rst_n (rst_n), .advance (advance),
        .tap_row0 (tap_row0), .tap_row1 (tap_row1), .tap_row2 (tap_row2),
        .win_00 (win_00), .win_01 (win_01), .win_02 (win_02),
        .win_10 (win_10), .win_11 (win_11), .win_12 (win_12),
        .win_20 (win_20), .win_21 (win_21), .win_22 (win_22)
    );

    gradient_x u_gradient_x (
        .clk    (clk), .rst_n (rst_n),
        .win_00 (win_00), .win_01 (win_01), .win_02 (win_02),
        .win_10 (win_10), .win_11 (win_11), .win_12 (win_12),
        .win_20 (win_20), .win_21 (win_21), .win_22 (win_22),
        .grad_x (grad_x)
    );

    gradient_y u_gradient_y (
        .clk    (clk), .rst_n (rst_n),
        .win_00 (win_00), .win_01 (win_01), .win_02 (win_02),
        .win_10 (win_10), .win_11 (win_11), .win_12 (win_12),
        .win_20 (win_20), .win_21 (win_21), .win_22 (win_22),
        .grad_y (grad_y)
    );

    edge_combine u_edge_combine (
        .clk           (clk),
        .rst_n         (rst_n),
        .grad_valid    (grad_valid),
        .grad_x        (grad_x),
        .grad_y        (grad_y),
        .out_valid     (out_valid),
        .out_magnitude (out_magnitude),
        .out_edge      (out_edge)
    );

endmodule

//--- design/stream_credit.sv
module stream_credit
    import sobel_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic out_credit,
    output logic in_credit,
    output logic advance,
    output logic grad_valid
);

    // Output slots not yet handed to the source as input grants.
    logic [CREDIT_WIDTH-1:0] credit_count;
    logic                    grant;
    logic                    win_valid;

    // A grant is only issued against a free output slot.
    assign grant = (credit_count != '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credit_count <= CREDIT_WIDTH'(OUT_CREDITS);
            in_credit    <= 1'b0;
        end
        else
        begin
            credit_count <= credit_count - CREDIT_WIDTH'(grant) + CREDIT_WIDTH'(out_credit);
            in_credit    <= grant;
        end
    end

    // Every pixel the source sends is backed by a grant, so it is always taken.
    assign advance = in_valid;

    // The valid travels with the window stage, then with the gradient stage.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            win_valid  <= 1'b0;
            grad_valid <= 1'b0;
        end
        else
        begin
            win_valid  <= in_valid;
            grad_valid <= win_valid;
        end
    end

endmodule

//--- design/edge_combine.sv
module edge_combine
    import sobel_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         grad_valid,
    input  logic signed [GRAD_WIDTH-1:0] grad_x,
    input  logic signed [GRAD_WIDTH-1:0] grad_y,
    output logic                         out_valid,
    output logic [MAG_WIDTH-1:0]         out_magnitude,
    output logic                         out_edge
);

    logic [GRAD_WIDTH-1:0] abs_x;
    logic [GRAD_WIDTH-1:0] abs_y;
    logic [SUM_WIDTH-1:0]  abs_sum;
    logic [MAG_WIDTH-1:0]  mag_sat;
    logic                  edge_hit;

    // Gradients stay within +/-1020, so negation never overflows.
    assign abs_x = grad_x[GRAD_WIDTH-1] ? GRAD_WIDTH'(-grad_x) : GRAD_WIDTH'(grad_x);
    assign abs_y = grad_y[GRAD_WIDTH-1] ? GRAD_WIDTH'(-grad_y) : GRAD_WIDTH'(grad_y);

    assign abs_sum = SUM_WIDTH'(abs_x) + SUM_WIDTH'(abs_y);

    assign mag_sat = (abs_sum > SUM_WIDTH'(MAG_MAX)) ? MAG_WIDTH'(MAG_MAX)
                                                       : abs_sum[MAG_WIDTH-1:0];

    assign edge_hit = (mag_sat > MAG_WIDTH'(EDGE_THRESHOLD));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid     <= 1'b0;
            out_magnitude <= '0;
            out_edge      <= 1'b0;
        end
        else
        begin
            out_valid     <= grad_valid;
            out_magnitude <= mag_sat;
            out_edge      <= edge_hit;
        end
    end

endmodule

//--- design/gradient_y.sv
module gradient_y
    import sobel_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [PIXEL_WIDTH-1:0]       win_00,
    input  logic [PIXEL_WIDTH-1:0]       win_01,
    input  logic [PIXEL_WIDTH-1:0]       win_02,
    input  logic [PIXEL_WIDTH-1:0]       win_10,
    input  logic [PIXEL_WIDTH-1:0]       win_11,
    input  logic [PIXEL_WIDTH-1:0]       win_12,
    input  logic [PIXEL_WIDTH-1:0]       win_20,
    input  logic [PIXEL_WIDTH-1:0]       win_21,
    input  logic [PIXEL_WIDTH-1:0]       win_22,
    output logic signed [GRAD_WIDTH-1:0] grad_y
);

    logic signed [GRAD_WIDTH-1:0] bottom_sum;
    logic signed [GRAD_WIDTH-1:0] top_sum;

    // Weights 1, 2, 1 across the columns of the newest and oldest rows.
    // The middle row has zero weight in the vertical kernel.
    assign bottom_sum = GRAD_WIDTH'(win_20) + (GRAD_WIDTH'(win_21) << 1) + GRAD_WIDTH'(win_22);
    assign top_sum    = GRAD_WIDTH'(win_00) + (GRAD_WIDTH'(win_01) << 1) + GRAD_WIDTH'(win_02);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            grad_y <= '0;
        end
        else
        begin
            grad_y <= bottom_sum - top_sum;
        end
    end

endmodule

//--- design/gradient_x.sv
module gradient_x
    import sobel_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [PIXEL_WIDTH-1:0]       win_00,
    input  logic [PIXEL_WIDTH-1:0]       win_01,
    input  logic [PIXEL_WIDTH-1:0]       win_02,
    input  logic [PIXEL_WIDTH-1:0]       win_10,
    input  logic [PIXEL_WIDTH-1:0]       win_11,
    input  logic [PIXEL_WIDTH-1:0]       win_12,
    input  logic [PIXEL_WIDTH-1:0]       win_20,
    input  logic [PIXEL_WIDTH-1:0]       win_21,
    input  logic [PIXEL_WIDTH-1:0]       win_22,
    output logic signed [GRAD_WIDTH-1:0] grad_x
);

    logic signed [GRAD_WIDTH-1:0] right_sum;
    logic signed [GRAD_WIDTH-1:0] left_sum;

    // Weights 1, 2, 1 down the rows of the newest and oldest columns.
    // The middle column has zero weight in the horizontal kernel.
    assign right_sum = GRAD_WIDTH'(win_02) + (GRAD_WIDTH'(win_12) << 1) + GRAD_WIDTH'(win_22);
    assign left_sum  = GRAD_WIDTH'(win_00) + (GRAD_WIDTH'(win_10) << 1) + GRAD_WIDTH'(win_20);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            grad_x <= '0;
        end
        else
        begin
            grad_x <= right_sum - left_sum;
        end
    end

endmodule

//--- design/window_regs.sv
module window_regs
    import sobel_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   advance,
    input  logic [PIXEL_WIDTH-1:0] tap_row0,
    input  logic [PIXEL_WIDTH-1:0] tap_row1,
    input  logic [PIXEL_WIDTH-1:0] tap_row2,
    output logic [PIXEL_WIDTH-1:0] win_00,
    output logic [PIXEL_WIDTH-1:0] win_01,
    output logic [PIXEL_WIDTH-1:0] win_02,
    output logic [PIXEL_WIDTH-1:0] win_10,
    output logic [PIXEL_WIDTH-1:0] win_11,
    output logic [PIXEL_WIDTH-1:0] win_12,
    output logic [PIXEL_WIDTH-1:0] win_20,
    output logic [PIXEL_WIDTH-1:0] win_21,
    output logic [PIXEL_WIDTH-1:0] win_22
);

    // Row 0 is the oldest line, so it is fed from the two-lines-back tap.
    // Column 2 takes the newest pixel and the older columns move towards 0.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            win_00 <= '0;
            win_01 <= '0;
            win_02 <= '0;
            win_10 <= '0;
            win_11 <= '0;
            win_12 <= '0;
            win_20 <= '0;
            win_21 <= '0;
            win_22 <= '0;
        end
        else if (advance)
        begin
            win_00 <= win_01;
            win_01 <= win_02;
            win_02 <= tap_row2;
            win_10 <= win_11;
            win_11 <= win_12;
            win_12 <= tap_row1;
            win_20 <= win_21;
            win_21 <= win_22;
            win_22 <= tap_row0;
        end
    end

endmodule

//--- design/line_buffer.sv
module line_buffer
    import sobel_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   advance,
    input  logic [PIXEL_WIDTH-1:0] pixel,
    output logic [PIXEL_WIDTH-1:0] tap_row0,
    output logic [PIXEL_WIDTH-1:0] tap_row1,
    output logic [PIXEL_WIDTH-1:0] tap_row2
);

    // Element i holds the pixel accepted i+1 advances ago.
    logic [PIXEL_WIDTH-1:0] chain [TAP_DEPTH];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < TAP_DEPTH; i++)
            begin
                chain[i] <= '0;
            end
        end
        else if (advance)
        begin
            chain[0] <= pixel;
            for (int i = 1; i < TAP_DEPTH; i++)
            begin
                chain[i] <= chain[i-1];
            end
        end
    end

    // The current pixel is the row 0 tap without any delay.
    assign tap_row0 = pixel;

    // One full line back.
    assign tap_row1 = chain[LINE_WIDTH-1];

    // Two full lines back.
    assign tap_row2 = chain[TAP_DEPTH-1];

endmodule

//--- design/sobel_pkg.sv
package sobel_pkg;

    // Grey pixel width of the input stream.
    localparam int PIXEL_WIDTH = 8;

    // Pixels per image line. This is also the tap distance of the line buffer.
    localparam int LINE_WIDTH = 16;

    // Depth of the line buffer delay chain, two full lines.
    localparam int TAP_DEPTH = 2 * LINE_WIDTH;

    // Signed gradient width, enough for +/-1020.
    localparam int GRAD_WIDTH = 11;

    // Width of the sum of two absolute gradients before saturation.
    localparam int SUM_WIDTH = GRAD_WIDTH + 1;

    // Output magnitude width and its saturation value.
    localparam int MAG_WIDTH = 8;
    localparam int MAG_MAX = (1 << MAG_WIDTH) - 1;

    // The edge flag is set when the magnitude is strictly above this value.
    localparam int EDGE_THRESHOLD = 96;

    // Output slots owned by the consumer at reset.
    localparam int OUT_CREDITS = 4;

    // Counter width able to hold OUT_CREDITS.
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDITS + 1);

endpackage
